// File: verilog/trs_cmd_pkg.sv
package trs_cmd_pkg;

  // command opcodes as sent by the ESP
  // any other byte value is an unknown command and is ignored
  typedef enum logic [7:0] {
    get_cookie  = 8'd0,   // reply COOKIE
    bram_poke   = 8'd1,   // addr lo, addr hi, data
    bram_peek   = 8'd2,   // addr lo, addr hi, reply data
    get_version = 8'd15   // reply {major, minor}
  } cmd_op_e;

  // decoder states
  typedef enum logic {
    idle        = 1'b0,   // waiting for an opcode
    read_params = 1'b1    // collecting parameter bytes
  } dec_state_e;

  // magic byte so the ESP can tell the board is alive
  localparam logic [7:0] COOKIE = 8'haf;

  // version reply packs major in [7:5], minor in [4:0]
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

  // largest parameter count of any command (poke)
  // also the depth of the parameter register set
  localparam int MAX_PARAMS = 3;

endpackage

// File: verilog/spi_frontend.sv
`timescale 1ns/1ns

module spi_frontend (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       sck,
  input  logic       mosi,
  input  logic       cs_n,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  output logic       frame_start,
  output logic       sck_fall,
  output logic       cs_active
);

  logic [2:0] sck_q;    // sync chain, [2] is oldest
  logic [2:0] cs_n_q;
  logic [1:0] mosi_q;   // data is stable around the rising edge, 2 stages do
  logic       sck_rise; // registered edge pulse
  logic [2:0] bit_cnt;  // bit position inside current byte
  logic [7:0] shift_q;  // received bits, msb first

  // pin synchronizers
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sck_q  <= 3'b000; // mode 0, sck idles low
      cs_n_q <= 3'b111; // no frame
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_n_q <= {cs_n_q[1:0], cs_n};
    end
  end

  always_ff @(posedge clk) begin
    mosi_q <= {mosi_q[0], mosi};
  end

  // edge pulses, registered so a pin edge shows up 3 clk later
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sck_rise    <= 1'b0;
      sck_fall    <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      sck_rise    <= sck_q[1] & ~sck_q[2];
      sck_fall    <= ~sck_q[1] & sck_q[2];
      frame_start <= ~cs_n_q[1] & cs_n_q[2]; // cs falling
    end
  end

  assign cs_active = ~cs_n_q[2]; // aligned with the registered pulses

  // bit counter, restarts with every frame
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt  <= 3'd0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= 3'd0;
      end else if (sck_rise) begin
        bit_cnt  <= bit_cnt + 3'd1;      // wraps after the 8th bit
        rx_valid <= (bit_cnt == 3'd7);   // one clk after last rising pulse
      end
    end
  end

  // sample mosi on sck rising edges
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      shift_q <= {shift_q[6:0], mosi_q[1]};
    end
  end

  assign rx_byte = shift_q; // complete while rx_valid is high

endmodule

// File: verilog/cmd_decode.sv
`timescale 1ns/1ns

module cmd_decode (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic [7:0]           rx_byte,
  input  logic                 rx_valid,
  input  logic                 frame_start,
  output logic                 action,
  output trs_cmd_pkg::cmd_op_e op,
  output logic [7:0]           param0,
  output logic [7:0]           param1,
  output logic [7:0]           param2
);

  import trs_cmd_pkg::*;

  localparam int CNT_W = $clog2(MAX_PARAMS + 1); // holds 0..MAX_PARAMS
  localparam int IDX_W = $clog2(MAX_PARAMS);     // slot index

  dec_state_e       state;
  logic [CNT_W-1:0] remaining;  // parameter bytes still to come
  logic [IDX_W-1:0] idx;        // next parameter slot
  logic             has_reply;  // command in flight answers back
  logic             skip_next;  // next byte is the reply slot, filler only
  logic             take_byte;  // byte counts for the decoder
  logic [7:0]       params [MAX_PARAMS];

  // filler byte during a reply is not a command byte
  assign take_byte = rx_valid & ~skip_next & ~frame_start;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= idle;
      remaining <= '0;
      idx       <= '0;
      has_reply <= 1'b0;
      skip_next <= 1'b0;
      action    <= 1'b0;
      op        <= get_cookie;
    end else begin
      action <= 1'b0;
      if (frame_start) begin
        // new frame aborts whatever was half collected
        state     <= idle;
        remaining <= '0;
        idx       <= '0;
        skip_next <= 1'b0;
      end else if (rx_valid && skip_next) begin
        skip_next <= 1'b0; // reply slot consumed
      end else if (take_byte) begin
        case (state)
          idle: begin
            op  <= cmd_op_e'(rx_byte);
            idx <= '0;
            case (cmd_op_e'(rx_byte))
              get_cookie, get_version: begin
                action    <= 1'b1; // no params, run at once
                skip_next <= 1'b1;
              end
              bram_poke: begin
                remaining <= CNT_W'(3);
                has_reply <= 1'b0;
                state     <= read_params;
              end
              bram_peek: begin
                remaining <= CNT_W'(2);
                has_reply <= 1'b1;
                state     <= read_params;
              end
              default: ; // unknown opcode, stay idle
            endcase
          end
          read_params: begin
            idx <= idx + IDX_W'(1);
            if (remaining == CNT_W'(1)) begin
              action    <= 1'b1;      // last param in
              skip_next <= has_reply;
              state     <= idle;
            end
            remaining <= remaining - CNT_W'(1);
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // parameter slots, kept until overwritten by the next command
  always_ff @(posedge clk) begin
    if (take_byte && state == read_params) begin
      params[idx] <= rx_byte;
    end
  end

  assign param0 = params[0]; // addr low
  assign param1 = params[1]; // addr high
  assign param2 = params[2]; // poke data

endmodule

// File: verilog/cmd_execute.sv
`timescale 1ns/1ns

module cmd_execute #(
  parameter int MEM_ADDR_W = 15
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 action,
  input  trs_cmd_pkg::cmd_op_e op,
  input  logic [7:0]           param0,
  input  logic [7:0]           param1,
  input  logic [7:0]           param2,
  output logic [7:0]           reply_byte,
  output logic                 reply_valid
);

  import trs_cmd_pkg::*;

  localparam int MEM_DEPTH = 2 ** MEM_ADDR_W;

  logic [7:0]            mem [MEM_DEPTH]; // emulated trs memory
  logic [MEM_ADDR_W-1:0] addr;
  logic                  wr_en;
  logic                  rd_en;
  logic                  const_en;   // cookie or version reply
  logic [7:0]            const_byte;
  logic [7:0]            rd_q;       // registered memory read
  logic                  rd_pend;    // peek data lands next cycle

  // param0 is addr low, only the needed bits of param1 are used
  assign addr = {param1[MEM_ADDR_W-9:0], param0};

  assign wr_en    = action && (op == bram_poke);
  assign rd_en    = action && (op == bram_peek);
  assign const_en = action && (op == get_cookie || op == get_version);

  always_comb begin
    case (op)
      get_cookie:  const_byte = COOKIE;
      get_version: const_byte = {VERSION_MAJOR, VERSION_MINOR};
      default:     const_byte = 8'h00;
    endcase
  end

  // single port memory, write and read share the address
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[addr] <= param2;
    end
    if (rd_en) begin
      rd_q <= mem[addr];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_pend     <= 1'b0;
      reply_valid <= 1'b0;
    end else begin
      rd_pend     <= rd_en;
      reply_valid <= rd_pend | const_en; // peek 2 clk, constants 1 clk
    end
  end

  // reply data
  always_ff @(posedge clk) begin
    if (rd_pend) begin
      reply_byte <= rd_q;
    end else if (const_en) begin
      reply_byte <= const_byte;
    end
  end

endmodule

// File: verilog/reply_shifter.sv
`timescale 1ns/1ns

module reply_shifter (
  input  logic       clk,
  input  logic       arst_n,
  input  logic [7:0] reply_byte,
  input  logic       reply_valid,
  input  logic       sck_fall,
  input  logic       cs_active,
  output logic       miso
);

  logic       pending; // reply waiting for the next sck fall
  logic [7:0] hold_q;  // reply until it is loaded
  logic [7:0] shift_q; // msb drives miso

  // capture the reply byte
  always_ff @(posedge clk) begin
    if (reply_valid) begin
      hold_q <= reply_byte;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= 1'b0;
      shift_q <= 8'h00;
    end else if (!cs_active) begin
      // frame over, drop anything not yet sent
      pending <= 1'b0;
      shift_q <= 8'h00;
    end else begin
      if (sck_fall) begin
        if (pending) begin
          shift_q <= hold_q; // bit 7 appears before the next rising edge
          pending <= 1'b0;
        end else begin
          shift_q <= {shift_q[6:0], 1'b0}; // zero fill once sent
        end
      end
      // a fresh reply wins over the load above
      if (reply_valid) begin
        pending <= 1'b1;
      end
    end
  end

  // pad tristate lives outside, here 0 when idle
  assign miso = shift_q[7];

endmodule

// File: verilog/trs_cmd_top.sv
`timescale 1ns/1ns

module trs_cmd_top #(
  parameter int MEM_ADDR_W = 15 // 32K trs memory
) (
  input  logic clk,
  input  logic arst_n,
  input  logic sck,
  input  logic mosi,
  input  logic cs_n,
  output logic miso
);

  import trs_cmd_pkg::*;

  logic [7:0] rx_byte;
  logic       rx_valid;
  logic       frame_start;
  logic       sck_fall;
  logic       cs_active;
  logic       action;
  cmd_op_e    op;
  logic [7:0] param0;
  logic [7:0] param1;
  logic [7:0] param2;
  logic [7:0] reply_byte;
  logic       reply_valid;

  // spi pins to bytes
  spi_frontend u_spi_frontend (
    .clk         (clk),
    .arst_n      (arst_n),
    .sck         (sck),
    .mosi        (mosi),
    .cs_n        (cs_n),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_start (frame_start),
    .sck_fall    (sck_fall),
    .cs_active   (cs_active)
  );

  // bytes to commands
  cmd_decode u_cmd_decode (
    .clk         (clk),
    .arst_n      (arst_n),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_start (frame_start),
    .action      (action),
    .op          (op),
    .param0      (param0),
    .param1      (param1),
    .param2      (param2)
  );

  cmd_execute #(
    .MEM_ADDR_W (MEM_ADDR_W)
  ) u_cmd_execute (
    .clk         (clk),
    .arst_n      (arst_n),
    .action      (action),
    .op          (op),
    .param0      (param0),
    .param1      (param1),
    .param2      (param2),
    .reply_byte  (reply_byte),
    .reply_valid (reply_valid)
  );

  // reply back out on miso
  reply_shifter u_reply_shifter (
    .clk         (clk),
    .arst_n      (arst_n),
    .reply_byte  (reply_byte),
    .reply_valid (reply_valid),
    .sck_fall    (sck_fall),
    .cs_active   (cs_active),
    .miso        (miso)
  );

endmodule

// File: dv/spi_master_tasks.svh
// spi master side of the link in mode 0 with msb first
// included inside tb_trs_cmd where it drives the pins and fills the buffers

localparam int HALF_SCK  = 10; // clk cycles per sck phase
localparam int IDLE_WAIT = 16; // miso has to drop within this after cs_n rises

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// one step per bit taken with the newest bit in the lsb
task automatic take_rand_bits(input int n, output logic [31:0] v);
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    v = {v[30:0], lfsr_state[0]};
  end
endtask

task automatic clk_falls(input int n);
  repeat (n) @(negedge clk);
endtask

// one byte each way
task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
  rx = '0;
  for (int i = 7; i >= 0; i--) begin
    mosi = tx[i];       // set up while sck is low
    clk_falls(HALF_SCK);
    rx[i] = miso;       // taken right at the rising edge
    sck = 1'b1;
    clk_falls(HALF_SCK);
    sck = 1'b0;         // dut loads or shifts miso on this edge
  end
endtask

// miso has to fall back to 0 once cs_n is high
task automatic wait_miso_idle();
  wait_what  = "miso low after cs_n went high";
  wait_limit = IDLE_WAIT;
  wait_cnt   = 0;
  while (miso !== 1'b0) begin
    clk_falls(1);
    wait_cnt++;
  end
  wait_cnt   = 0;
  wait_limit = MAX_CYCLES; // no wait in progress
endtask

// whole cs frame sent from tx_buf with the received bytes in rx_buf
task automatic run_frame(input int n);
  cs_n = 1'b0;
  clk_falls(HALF_SCK);
  for (int i = 0; i < n; i++) begin
    spi_byte(tx_buf[i], rx_buf[i]);
  end
  clk_falls(HALF_SCK);
  cs_n = 1'b1;
  wait_miso_idle();
  clk_falls(2 * HALF_SCK); // gap so the next cs fall is seen as a new frame
endtask

// File: dv/tb_trs_cmd.sv
`timescale 1ns/1ns

module tb_trs_cmd;

  import trs_cmd_pkg::*;

  localparam int MEM_ADDR_W = 15;     // 32K like the board
  localparam int N_POKES    = 20;
  localparam int MAX_CYCLES = 200000; // whole run budget

  logic        clk;
  logic        arst_n;
  logic        sck;
  logic        mosi;
  logic        cs_n;
  logic        miso;

  logic [31:0] lfsr_state;
  logic [7:0]  tx_buf [8];
  logic [7:0]  rx_buf [8];
  logic [7:0]  ref_mem [int unsigned]; // expected memory contents
  int unsigned addr_list [N_POKES];
  int          check_cnt;
  int          err_cnt;
  int          test_cnt;
  int          chk_mark;   // counts at the start of a test
  int          err_mark;
  int          wait_cnt  = 0;  // clk spent in the current wait
  int          wait_limit = MAX_CYCLES;
  string       wait_what = "nothing";
  int          cycle_cnt = 0;

  `include "spi_master_tasks.svh"

  trs_cmd_top #(
    .MEM_ADDR_W (MEM_ADDR_W)
  ) UUT (
    .clk    (clk),
    .arst_n (arst_n),
    .sck    (sck),
    .mosi   (mosi),
    .cs_n   (cs_n),
    .miso   (miso)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  // timeouts for the current wait and for the whole run
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (wait_cnt > wait_limit) begin
      $display("timeout: no %s within %0d clk cycles", wait_what, wait_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end else if (cycle_cnt > MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d clk cycles", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s expected %02h got %02h", $time, what, exp, got);
      err_cnt++;
    end
  endtask

  task automatic start_test();
    chk_mark = check_cnt;
    err_mark = err_cnt;
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d checks, %0d errors", test_cnt, name,
             check_cnt - chk_mark, err_cnt - err_mark);
  endtask

  task automatic rand_addr(output int unsigned a);
    logic [31:0] v;
    take_rand_bits(MEM_ADDR_W, v);
    a = v;
  endtask

  // high byte carries random junk above the used address bits
  task automatic addr_bytes(input int unsigned a, output logic [7:0] lo,
                            output logic [7:0] hi);
    logic [31:0] junk;
    take_rand_bits(16 - MEM_ADDR_W, junk);
    lo = a[7:0];
    hi = 8'((a >> 8) | (junk << (MEM_ADDR_W - 8)));
  endtask

  // cookie or version with the reply in the filler byte
  task automatic const_cmd(input cmd_op_e cmd, input logic [7:0] exp, input string what);
    tx_buf[0] = cmd;
    tx_buf[1] = 8'h00;
    run_frame(2);
    check_byte(what, rx_buf[1], exp);
  endtask

  task automatic poke(input int unsigned a, input logic [7:0] d);
    logic [7:0] lo;
    logic [7:0] hi;
    addr_bytes(a, lo, hi);
    tx_buf[0] = bram_poke;
    tx_buf[1] = lo;
    tx_buf[2] = hi;
    tx_buf[3] = d;
    run_frame(4);
    ref_mem[a] = d; // last write wins
  endtask

  task automatic peek(input int unsigned a);
    logic [7:0] lo;
    logic [7:0] hi;
    addr_bytes(a, lo, hi);
    tx_buf[0] = bram_peek;
    tx_buf[1] = lo;
    tx_buf[2] = hi;
    tx_buf[3] = 8'h00; // reply slot
    run_frame(4);
    check_byte($sformatf("peek %04h", a), rx_buf[3], ref_mem[a]);
  endtask

  initial begin
    int unsigned a;
    logic [31:0] d;
    arst_n     = 1'b0;
    sck        = 1'b0; // mode 0 idle
    mosi       = 1'b0;
    cs_n       = 1'b1;
    lfsr_state = 32'hf61a6e91;
    check_cnt  = 0;
    err_cnt    = 0;
    test_cnt   = 0;
    clk_falls(8);
    arst_n = 1'b1;
    clk_falls(4);

    start_test();
    const_cmd(get_cookie, COOKIE, "cookie");
    finish_test("get_cookie");

    start_test();
    const_cmd(get_version, {VERSION_MAJOR, VERSION_MINOR}, "version");
    finish_test("get_version");

    start_test();
    for (int i = 0; i < N_POKES; i++) begin
      rand_addr(a);
      take_rand_bits(8, d);
      addr_list[i] = a;
      poke(a, d[7:0]);
    end
    for (int i = 0; i < N_POKES; i++) begin
      peek(addr_list[i]);
    end
    finish_test("random poke and peek");

    start_test();
    rand_addr(a);
    take_rand_bits(8, d);
    poke(a, d[7:0]);
    poke(a, ~d[7:0]); // second value differs in every bit
    peek(a);
    finish_test("double poke");

    // poke cut short after addr low leaves the old byte in memory
    start_test();
    tx_buf[0] = bram_poke;
    tx_buf[1] = a[7:0];
    run_frame(2);
    peek(a);
    const_cmd(get_cookie, COOKIE, "cookie after abort");
    finish_test("abort");

    start_test();
    tx_buf[0] = 8'h07; // not a known opcode
    run_frame(1);
    const_cmd(get_cookie, COOKIE, "cookie after unknown");
    finish_test("unknown opcode");

    $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+dv
verilog/trs_cmd_pkg.sv
verilog/spi_frontend.sv
verilog/cmd_decode.sv
verilog/cmd_execute.sv
verilog/reply_shifter.sv
verilog/trs_cmd_top.sv
dv/tb_trs_cmd.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the trs command channel testbench with verilator, run it, judge from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG" &&
  verilator --binary --timing --assert -f sources.f --top-module tb_trs_cmd \
    -Mdir obj_dir -o vsim_tb > build.log 2>&1 ||
  { echo "build failed, see build.log"; exit 1; }

./obj_dir/vsim_tb > "$LOG" 2>&1
cat "$LOG"

grep -qx "TESTBENCH PASSED" "$LOG" &&
  { echo "result: pass"; exit 0; } ||
  { echo "result: fail"; exit 1; }
